// File: include/fpm_config.svh
`ifndef FPM_CONFIG_SVH
`define FPM_CONFIG_SVH

// exponent widths
`define FPM_EXP_W 8
`define FPM_WEXP_W 10
`define FPM_SHIFT_W 6

// operand fully shifted out past this
`define FPM_MANT_BITS 40

// flow control
`define FPM_IN_CREDITS 2
`define FPM_OUT_CREDITS 2

// float op codes
`define FPM_OP_AF 2'd0
`define FPM_OP_SF 2'd1
`define FPM_OP_MF 2'd2
`define FPM_OP_DF 2'd3

`endif

// File: verilog/fpm_pkg.sv
`include "fpm_config.svh"

package fpm_pkg;

	// operand and result exponent
	typedef logic signed [`FPM_EXP_W-1:0] exp_t;

	// exponent with two guard bits
	typedef logic signed [`FPM_WEXP_W-1:0] wexp_t;

	// alignment count, 0..40
	typedef logic [`FPM_SHIFT_W-1:0] shift_t;

	typedef logic [1:0] op_t;

	// sequencer states
	typedef enum logic [1:0] {
		st_idle,
		st_calc,
		st_align,
		st_emit
	} ctrl_state_t;

endpackage

// File: verilog/fpm_exp_unit.sv
`timescale 1ns/1ps
`include "fpm_config.svh"

module fpm_exp_unit (
	input  logic            f2strob,
	input  logic            _0_d_,
	input  logic            exp_load,
	input  fpm_pkg::op_t    exp_op,
	input  fpm_pkg::exp_t   exp_ea,
	input  fpm_pkg::exp_t   exp_eb,
	output fpm_pkg::wexp_t  sum,
	output fpm_pkg::shift_t shift,
	output logic            swap,
	output logic            far,
	output logic            ovf,
	output logic            unf
);

	fpm_pkg::wexp_t d_reg;
	fpm_pkg::wexp_t b_reg;
	fpm_pkg::op_t op_reg;
	fpm_pkg::wexp_t b_bus;
	fpm_pkg::wexp_t add_out;
	logic [`FPM_WEXP_W-1:0] mag;
	logic addsub;
	logic b_inv;

	// D and B registers, sign extended into the guard bits
	always_ff @(posedge f2strob) begin
		if (exp_load) begin
			d_reg <= {{(`FPM_WEXP_W-`FPM_EXP_W){exp_ea[`FPM_EXP_W-1]}}, exp_ea};
			b_reg <= {{(`FPM_WEXP_W-`FPM_EXP_W){exp_eb[`FPM_EXP_W-1]}}, exp_eb};
		end
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			op_reg <= `FPM_OP_AF;
		end else if (exp_load) begin
			op_reg <= exp_op;
		end
	end

	assign addsub = (op_reg == `FPM_OP_AF) || (op_reg == `FPM_OP_SF);

	// only multiply adds B as is, everything else subtracts
	assign b_inv = (op_reg != `FPM_OP_MF);
	assign b_bus = b_inv ? ~b_reg : b_reg;
	assign add_out = d_reg + b_bus + {{(`FPM_WEXP_W-1){1'b0}}, b_inv};

	assign mag = add_out[`FPM_WEXP_W-1] ? -add_out : add_out;

	// range detectors and exponent mux
	always_comb begin
		swap = 1'b0;
		far = 1'b0;
		shift = '0;
		ovf = 1'b0;
		unf = 1'b0;
		sum = add_out;
		if (addsub) begin
			swap = add_out[`FPM_WEXP_W-1];
			far = (mag >= `FPM_MANT_BITS);
			if (far) begin
				shift = `FPM_SHIFT_W'(`FPM_MANT_BITS);
			end else begin
				shift = mag[`FPM_SHIFT_W-1:0];
			end
			// keep the larger exponent
			sum = swap ? b_reg : d_reg;
		end else begin
			ovf = (add_out > 10'sd127);
			unf = (add_out < -10'sd128);
		end
	end

	// detectors settle within the cycle after a load
	a_flags_known: assert property (
		@(posedge f2strob) disable iff (!_0_d_)
		exp_load |=> !$isunknown({sum, shift, swap, far, ovf, unf})
	);

endmodule

// File: verilog/fpm_shift_cnt.sv
`timescale 1ns/1ps
`include "fpm_config.svh"

module fpm_shift_cnt (
	input  logic            f2strob,
	input  logic            _0_d_,
	input  logic            cnt_load,
	input  fpm_pkg::shift_t cnt_value,
	output logic            cnt_zero
);

	fpm_pkg::shift_t cnt;

	// one alignment step per clock
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			cnt <= '0;
		end else if (cnt_load) begin
			cnt <= cnt_value;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign cnt_zero = (cnt == '0);

	// parked at zero until the next load
	a_no_underflow: assert property (
		@(posedge f2strob) disable iff (!_0_d_)
		(cnt_zero && !cnt_load) |=> cnt_zero
	);

endmodule

// File: verilog/fpm_ctrl.sv
`timescale 1ns/1ps
`include "fpm_config.svh"

module fpm_ctrl (
	input  logic            f2strob,
	input  logic            _0_d_,
	input  logic            req_valid,
	input  fpm_pkg::op_t    req_op,
	input  fpm_pkg::exp_t   req_ea,
	input  fpm_pkg::exp_t   req_eb,
	output logic            in_credit,
	output logic            exp_load,
	output fpm_pkg::op_t    exp_op,
	output fpm_pkg::exp_t   exp_ea,
	output fpm_pkg::exp_t   exp_eb,
	input  logic            far,
	input  fpm_pkg::shift_t shift,
	output logic            cnt_load,
	output fpm_pkg::shift_t cnt_value,
	input  logic            cnt_zero,
	input  logic            out_credit,
	output logic            res_valid
);

	fpm_pkg::ctrl_state_t state;
	fpm_pkg::op_t q_op [`FPM_IN_CREDITS];
	fpm_pkg::exp_t q_ea [`FPM_IN_CREDITS];
	fpm_pkg::exp_t q_eb [`FPM_IN_CREDITS];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] q_count;
	logic [1:0] out_cnt;
	fpm_pkg::op_t cur_op;
	logic pop;
	logic need_align;

	// request queue
	always_ff @(posedge f2strob) begin
		if (req_valid) begin
			q_op[wr_ptr] <= req_op;
			q_ea[wr_ptr] <= req_ea;
			q_eb[wr_ptr] <= req_eb;
		end
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			q_count <= 2'd0;
		end else begin
			if (req_valid) begin
				wr_ptr <= ~wr_ptr;
			end
			if (pop) begin
				rd_ptr <= ~rd_ptr;
			end
			q_count <= q_count + {1'b0, req_valid} - {1'b0, pop};
		end
	end

	assign pop = (state == fpm_pkg::st_idle) && (q_count != 2'd0);

	// head goes straight to the D/B registers
	assign exp_load = pop;
	assign exp_op = q_op[rd_ptr];
	assign exp_ea = q_ea[rd_ptr];
	assign exp_eb = q_eb[rd_ptr];

	assign need_align = ((cur_op == `FPM_OP_AF) || (cur_op == `FPM_OP_SF)) &&
		!far && (shift != '0);
	assign cnt_load = (state == fpm_pkg::st_calc) && need_align;
	assign cnt_value = shift;

	// result credits, spent while res_valid is up
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			out_cnt <= 2'(`FPM_OUT_CREDITS);
		end else begin
			out_cnt <= out_cnt + {1'b0, out_credit} - {1'b0, res_valid};
		end
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			state <= fpm_pkg::st_idle;
			cur_op <= `FPM_OP_AF;
			in_credit <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			in_credit <= pop;
			res_valid <= 1'b0;
			case (state)
				fpm_pkg::st_idle: begin
					if (pop) begin
						cur_op <= exp_op;
						state <= fpm_pkg::st_calc;
					end
				end
				fpm_pkg::st_calc: begin
					state <= need_align ? fpm_pkg::st_align : fpm_pkg::st_emit;
				end
				fpm_pkg::st_align: begin
					if (cnt_zero) begin
						state <= fpm_pkg::st_emit;
					end
				end
				fpm_pkg::st_emit: begin
					// hold here under back-pressure
					if (out_cnt != 2'd0) begin
						res_valid <= 1'b1;
						state <= fpm_pkg::st_idle;
					end
				end
				default: state <= fpm_pkg::st_idle;
			endcase
		end
	end

	// upstream only sends while it holds a credit
	a_no_push_full: assert property (
		@(posedge f2strob) disable iff (!_0_d_)
		req_valid |-> (q_count < `FPM_IN_CREDITS)
	);

	a_credit_max: assert property (
		@(posedge f2strob) disable iff (!_0_d_)
		out_cnt <= `FPM_OUT_CREDITS
	);

	a_valid_credit: assert property (
		@(posedge f2strob) disable iff (!_0_d_)
		res_valid |-> (out_cnt != 2'd0)
	);

endmodule

// File: verilog/fpm_top.sv
`timescale 1ns/1ps
`include "fpm_config.svh"

module fpm_top (
	input  logic            f2strob,
	input  logic            _0_d_,
	input  logic            req_valid,
	input  fpm_pkg::op_t    req_op,
	input  fpm_pkg::exp_t   req_ea,
	input  fpm_pkg::exp_t   req_eb,
	output logic            in_credit,
	input  logic            out_credit,
	output logic            res_valid,
	output fpm_pkg::exp_t   res_exp,
	output fpm_pkg::shift_t res_shift,
	output logic            res_swap,
	output logic            res_far,
	output logic            res_ovf,
	output logic            res_unf
);

	logic exp_load;
	fpm_pkg::op_t exp_op;
	fpm_pkg::exp_t exp_ea;
	fpm_pkg::exp_t exp_eb;
	fpm_pkg::wexp_t sum;
	fpm_pkg::shift_t shift;
	logic far;
	logic cnt_load;
	fpm_pkg::shift_t cnt_value;
	logic cnt_zero;

	fpm_ctrl fpm_ctrl_i (
		.f2strob    (f2strob),
		._0_d_      (_0_d_),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_ea     (req_ea),
		.req_eb     (req_eb),
		.in_credit  (in_credit),
		.exp_load   (exp_load),
		.exp_op     (exp_op),
		.exp_ea     (exp_ea),
		.exp_eb     (exp_eb),
		.far        (far),
		.shift      (shift),
		.cnt_load   (cnt_load),
		.cnt_value  (cnt_value),
		.cnt_zero   (cnt_zero),
		.out_credit (out_credit),
		.res_valid  (res_valid)
	);

	fpm_exp_unit fpm_exp_unit_i (
		.f2strob  (f2strob),
		._0_d_    (_0_d_),
		.exp_load (exp_load),
		.exp_op   (exp_op),
		.exp_ea   (exp_ea),
		.exp_eb   (exp_eb),
		.sum      (sum),
		.shift    (shift),
		.swap     (res_swap),
		.far      (far),
		.ovf      (res_ovf),
		.unf      (res_unf)
	);

	fpm_shift_cnt fpm_shift_cnt_i (
		.f2strob   (f2strob),
		._0_d_     (_0_d_),
		.cnt_load  (cnt_load),
		.cnt_value (cnt_value),
		.cnt_zero  (cnt_zero)
	);

	// guard bits dropped on the way out
	assign res_exp = sum[`FPM_EXP_W-1:0];
	assign res_shift = shift;
	assign res_far = far;

endmodule

// File: dv/fpm_tb.sv
`timescale 1ns/1ps
`include "fpm_config.svh"

module fpm_tb;

	// 7 align + 8 mul/div + 4 back-pressure + 40 random
	localparam int num_reqs = 59;
	localparam int cycle_ns = 10;

	logic f2strob;
	logic _0_d_;
	logic req_valid;
	fpm_pkg::op_t req_op;
	fpm_pkg::exp_t req_ea;
	fpm_pkg::exp_t req_eb;
	logic in_credit;
	logic out_credit;
	logic res_valid;
	fpm_pkg::exp_t res_exp;
	fpm_pkg::shift_t res_shift;
	logic res_swap;
	logic res_far;
	logic res_ovf;
	logic res_unf;

	// {exp[17:10], shift[9:4], swap, far, ovf, unf}
	logic [17:0] exp_q [$];
	int credits;
	int in_pulses;
	int res_count;
	int owed;
	int sent;
	// 0 hold, 1 return at once, 2 random
	int credit_mode;
	logic [31:0] op_rng;
	logic [31:0] credit_rng;

	fpm_top fpm_top_i (.*);

	always #5 f2strob = ~f2strob;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			stop_run($sformatf("error at %0t: %s is %0h, expected %0h", $time, what, got, want));
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [17:0] ref_result(input fpm_pkg::op_t op,
		input fpm_pkg::exp_t ea, input fpm_pkg::exp_t eb);
		int a;
		int b;
		int d;
		int mag;
		logic [7:0] e;
		logic [5:0] sh;
		logic sw;
		logic fr;
		logic ov;
		logic un;
		a = ea;
		b = eb;
		sh = '0;
		sw = 1'b0;
		fr = 1'b0;
		ov = 1'b0;
		un = 1'b0;
		if (op == `FPM_OP_AF || op == `FPM_OP_SF) begin
			d = a - b;
			sw = (d < 0);
			mag = sw ? -d : d;
			fr = (mag >= `FPM_MANT_BITS);
			sh = 6'(fr ? `FPM_MANT_BITS : mag);
			e = sw ? eb : ea;
		end else begin
			d = (op == `FPM_OP_MF) ? a + b : a - b;
			ov = (d > 127);
			un = (d < -128);
			e = d[7:0];
		end
		return {e, sh, sw, fr, ov, un};
	endfunction

	task automatic send_req(input fpm_pkg::op_t op, input fpm_pkg::exp_t ea,
		input fpm_pkg::exp_t eb);
		@(posedge f2strob);
		while (credits == 0) begin
			@(posedge f2strob);
		end
		req_valid <= 1'b1;
		req_op <= op;
		req_ea <= ea;
		req_eb <= eb;
		credits--;
		sent++;
		exp_q.push_back(ref_result(op, ea, eb));
		@(posedge f2strob);
		req_valid <= 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0 || owed != 0 || out_credit) begin
			@(negedge f2strob);
		end
	endtask

	task automatic return_credit();
		@(posedge f2strob);
		out_credit <= 1'b1;
		@(posedge f2strob);
		out_credit <= 1'b0;
	endtask

	// receiver returns only the credits it was spent
	always @(posedge f2strob) begin
		if (credit_mode != 0) begin
			credit_rng = xorshift(credit_rng);
			out_credit <= (owed > 0) && (credit_mode == 1 || credit_rng[0]);
		end
	end

	always @(negedge f2strob) begin
		logic [17:0] e;
		if (in_credit) begin
			credits++;
			in_pulses++;
		end
		if (out_credit) begin
			owed--;
		end
		if (res_valid) begin
			if (exp_q.size() == 0) begin
				stop_run("a result came out with no request outstanding");
			end else begin
				e = exp_q.pop_front();
				check_value("res_exp", {res_exp}, e[17:10]);
				check_value("res_shift", {res_shift}, e[9:4]);
				check_value("res_swap", res_swap, e[3]);
				check_value("res_far", res_far, e[2]);
				check_value("res_ovf", res_ovf, e[1]);
				check_value("res_unf", res_unf, e[0]);
				res_count++;
				owed++;
			end
		end
	end

	task automatic reset_quiet();
		repeat (10) begin
			@(negedge f2strob);
			check_value("res_valid after reset", res_valid, 1'b0);
			check_value("in_credit after reset", in_credit, 1'b0);
		end
	endtask

	task automatic align_cases();
		send_req(`FPM_OP_AF, 8'sd5, 8'sd5);
		send_req(`FPM_OP_AF, 8'sd10, 8'sd3);
		send_req(`FPM_OP_SF, -8'sd20, 8'sd15);
		send_req(`FPM_OP_AF, 8'sd50, 8'sd11);
		send_req(`FPM_OP_AF, -8'sd60, -8'sd20);
		send_req(`FPM_OP_SF, 8'sd100, -8'sd100);
		send_req(`FPM_OP_AF, 8'sd127, 8'h80);
		wait_drained();
	endtask

	task automatic mul_div_cases();
		send_req(`FPM_OP_MF, 8'sd30, 8'sd40);
		send_req(`FPM_OP_DF, -8'sd50, 8'sd20);
		send_req(`FPM_OP_MF, 8'sd64, 8'sd63);
		send_req(`FPM_OP_DF, -8'sd64, 8'sd64);
		send_req(`FPM_OP_MF, 8'sd100, 8'sd50);
		send_req(`FPM_OP_DF, 8'sd127, 8'h80);
		send_req(`FPM_OP_MF, -8'sd100, -8'sd60);
		send_req(`FPM_OP_DF, 8'h80, 8'sd127);
		wait_drained();
	endtask

	// two results use up the output credits and the queue fills
	task automatic back_pressure();
		int res0;
		int pul0;
		credit_mode = 0;
		res0 = res_count;
		pul0 = in_pulses;
		for (int i = 0; i < 4; i++) begin
			send_req(`FPM_OP_AF, fpm_pkg::exp_t'(3 * i), '0);
		end
		while (res_count - res0 < 2) @(negedge f2strob);
		repeat (20) @(negedge f2strob);
		check_value("results under back-pressure", res_count - res0, 2);
		check_value("in_credit pulses under back-pressure", in_pulses - pul0, 3);
		return_credit();
		while (res_count - res0 < 3) @(negedge f2strob);
		repeat (20) @(negedge f2strob);
		check_value("results after one credit", res_count - res0, 3);
		check_value("in_credit pulses after one credit", in_pulses - pul0, 4);
		return_credit();
		while (res_count - res0 < 4) @(negedge f2strob);
		credit_mode = 1;
		wait_drained();
		check_value("input credits after back-pressure", credits, `FPM_IN_CREDITS);
	endtask

	task automatic random_traffic();
		credit_mode = 2;
		repeat (40) begin
			op_rng = xorshift(op_rng);
			send_req(op_rng[1:0], op_rng[15:8], op_rng[23:16]);
		end
		credit_mode = 1;
		wait_drained();
	endtask

	initial begin
		#(num_reqs * 60 * cycle_ns);
		stop_run("the run timed out before all results arrived");
	end

	initial begin
		f2strob = 1'b0;
		_0_d_ = 1'b0;
		req_valid = 1'b0;
		req_op = '0;
		req_ea = '0;
		req_eb = '0;
		out_credit = 1'b0;
		credits = `FPM_IN_CREDITS;
		in_pulses = 0;
		res_count = 0;
		owed = 0;
		sent = 0;
		credit_mode = 1;
		op_rng = 32'd56263;
		credit_rng = 32'd56263;
		repeat (2) @(posedge f2strob);
		_0_d_ <= 1'b1;
		reset_quiet();
		align_cases();
		mul_div_cases();
		back_pressure();
		random_traffic();
		check_value("total in_credit pulses", in_pulses, sent);
		if (exp_q.size() == 0 && res_count == sent) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_run("some results never came out");
		end
	end

endmodule

// File: filelist.f
+incdir+include
verilog/fpm_pkg.sv
verilog/fpm_exp_unit.sv
verilog/fpm_shift_cnt.sv
verilog/fpm_ctrl.sv
verilog/fpm_top.sv
dv/fpm_tb.sv

// File: Bender.yml
package:
  name: fpm

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/fpm_pkg.sv
      - verilog/fpm_exp_unit.sv
      - verilog/fpm_shift_cnt.sv
      - verilog/fpm_ctrl.sv
      - verilog/fpm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/fpm_tb.sv
